// File: source/pdl_config.svh
// Sizes of the PDL memory, shared by the RTL and the testbench
// Include wherever a word width, address width or depth is needed

`ifndef PDL_CONFIG_SVH
`define PDL_CONFIG_SVH

//----------------------------------------------------------------------
// Memory geometry
//----------------------------------------------------------------------

// Word address, wraps at the top of the list
`define PDL_ADDR_W 10

// One Lisp word
`define PDL_DATA_W 32

// Words in the list, 2**PDL_ADDR_W
`define PDL_DEPTH 1024

`endif

// File: source/pdl_pkg.sv
// Types shared by the PDL engine, the spy port and the dual-port RAM
// Modules import it inside their bodies and use scoped names in headers

`include "pdl_config.svh"

package pdl_pkg;

   //----------------------------------------------------------------------
   // Engine commands
   //----------------------------------------------------------------------

   typedef enum logic [2:0] {
      op_push      = 3'd0,
      op_pop       = 3'd1,
      op_read_idx  = 3'd2,
      op_write_idx = 3'd3,
      op_set_ptr   = 3'd4,
      op_set_idx   = 3'd5
   } pdl_op_e;

   typedef struct packed {
      pdl_op_e                op;
      logic [`PDL_ADDR_W-1:0] addr;   // New pointer or index value
      logic [`PDL_DATA_W-1:0] data;   // Word for push and write_idx
   } pdl_cmd_t;

   typedef struct packed {
      logic [`PDL_DATA_W-1:0] data;
   } pdl_resp_t;

   //----------------------------------------------------------------------
   // Host access and RAM ports
   //----------------------------------------------------------------------

   typedef struct packed {
      logic                   write;
      logic [`PDL_ADDR_W-1:0] addr;
      logic [`PDL_DATA_W-1:0] data;
   } spy_req_t;

   typedef struct packed {
      logic [`PDL_ADDR_W-1:0] addr;
      logic [`PDL_DATA_W-1:0] wdata;
      logic                   wren;
      logic                   rden;
   } ram_port_t;

endpackage

// File: source/pdl_dpram.sv
// 1k x 32 dual-port synchronous RAM holding the push-down list
// Port A serves the PDL engine, port B the host spy port

`include "pdl_config.svh"

module pdl_dpram
(
   input  logic                   clk_a,
   input  logic                   reset,
   input  pdl_pkg::ram_port_t     port_a,
   input  pdl_pkg::ram_port_t     port_b,
   output logic [`PDL_DATA_W-1:0] q_a,
   output logic [`PDL_DATA_W-1:0] q_b
);

   logic [`PDL_DATA_W-1:0] ram [0:`PDL_DEPTH-1];

   //----------------------------------------------------------------------
   // Write side
   //----------------------------------------------------------------------

   // Both ports share one write process; the sequencers never collide
   always_ff @(posedge clk_a)
   begin
      if (port_a.wren)
      begin
         ram[port_a.addr] <= port_a.wdata;
      end
      if (port_b.wren)
      begin
         ram[port_b.addr] <= port_b.wdata;
      end
   end

   //----------------------------------------------------------------------
   // Read registers, old data on a same-cycle write
   //----------------------------------------------------------------------

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_a <= '0;
      end
      else if (port_a.rden)
      begin
         q_a <= ram[port_a.addr];
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_b <= '0;
      end
      else if (port_b.rden)
      begin
         q_b <= ram[port_b.addr];   // Held until the next read
      end
   end

   // Spy port must have backed off any write that meets an engine write
   a_no_dual_write : assert property (@(posedge clk_a) disable iff (reset)
      !(port_a.wren && port_b.wren));

endmodule

// File: source/pdl_pointer.sv
// Stack pointer and index register of the PDL engine
// Gives the RAM address of the current op and steps the registers on acceptance

`include "pdl_config.svh"

module pdl_pointer
(
   input  logic                   clk_a,
   input  logic                   reset,
   input  logic                   step,
   input  pdl_pkg::pdl_op_e       op,
   input  logic [`PDL_ADDR_W-1:0] addr,
   output logic [`PDL_ADDR_W-1:0] ram_addr
);

   import pdl_pkg::*;

   localparam logic [`PDL_ADDR_W-1:0] addr_one = 'd1;

   logic [`PDL_ADDR_W-1:0] ptr;       // Top of stack, last word pushed
   logic [`PDL_ADDR_W-1:0] idx;
   logic [`PDL_ADDR_W-1:0] ptr_inc;
   logic [`PDL_ADDR_W-1:0] ptr_dec;

   // Modulo 1024 by width
   assign ptr_inc = ptr + addr_one;
   assign ptr_dec = ptr - addr_one;

   //----------------------------------------------------------------------
   // Address select
   //----------------------------------------------------------------------

   always_comb
   begin
      case (op)
         op_push:
         begin
            ram_addr = ptr_inc;   // Pre-increment
         end
         op_pop:
         begin
            ram_addr = ptr;       // Post-decrement
         end
         default:
         begin
            ram_addr = idx;
         end
      endcase
   end

   //----------------------------------------------------------------------
   // Register update
   //----------------------------------------------------------------------

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         ptr <= '0;
      end
      else if (step)
      begin
         case (op)
            op_push:    ptr <= ptr_inc;
            op_pop:     ptr <= ptr_dec;
            op_set_ptr: ptr <= addr;
            default:    ptr <= ptr;
         endcase
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         idx <= '0;
      end
      else if (step && op == op_set_idx)
      begin
         idx <= addr;
      end
   end

endmodule

// File: source/pdl_engine.sv
// PDL command sequencer driving RAM port A
// Takes commands on a valid/ready stream and returns pop and read_idx results

`include "pdl_config.svh"

module pdl_engine
(
   input  logic                   clk_a,
   input  logic                   reset,
   input  pdl_pkg::pdl_cmd_t      cmd,
   input  logic                   cmd_valid,
   output logic                   cmd_ready,
   output pdl_pkg::pdl_resp_t     resp,
   output logic                   resp_valid,
   input  logic                   resp_ready,
   output pdl_pkg::ram_port_t     port_a,
   input  logic [`PDL_DATA_W-1:0] q_a,
   output logic                   a_write
);

   import pdl_pkg::*;

   logic                   accept;
   logic                   is_read;
   logic                   is_write;
   logic [`PDL_ADDR_W-1:0] ram_addr;

   //----------------------------------------------------------------------
   // Command acceptance
   //----------------------------------------------------------------------

   // Stall only while a result sits unclaimed
   assign cmd_ready = !resp_valid || resp_ready;
   assign accept    = cmd_valid && cmd_ready;

   always_comb
   begin
      is_read  = 1'b0;
      is_write = 1'b0;
      case (cmd.op)
         op_pop, op_read_idx:
         begin
            is_read = 1'b1;
         end
         op_push, op_write_idx:
         begin
            is_write = 1'b1;
         end
         default:
         begin
            is_read  = 1'b0;   // set_ptr and set_idx touch no RAM
            is_write = 1'b0;
         end
      endcase
   end

   pdl_pointer u_pdl_pointer
   (
      .clk_a    (clk_a),
      .reset    (reset),
      .step     (accept),
      .op       (cmd.op),
      .addr     (cmd.addr),
      .ram_addr (ram_addr)
   );

   //----------------------------------------------------------------------
   // RAM port A, issued in the accepting cycle
   //----------------------------------------------------------------------

   always_comb
   begin
      port_a.addr  = ram_addr;
      port_a.wdata = cmd.data;
      port_a.wren  = accept && is_write;
      port_a.rden  = accept && is_read;
   end

   assign a_write = port_a.wren;   // Lets the spy port stay clear

   //----------------------------------------------------------------------
   // Response
   //----------------------------------------------------------------------

   // q_a only moves on rden, so it doubles as the held response
   assign resp.data = q_a;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         resp_valid <= 1'b0;
      end
      else if (accept && is_read)
      begin
         resp_valid <= 1'b1;
      end
      else if (resp_ready)
      begin
         resp_valid <= 1'b0;
      end
   end

   a_resp_hold : assert property (@(posedge clk_a) disable iff (reset)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp));

endmodule

// File: source/pdl_spy_port.sv
// Host debug access to the PDL through RAM port B
// Reads return on spy_rdata; writes wait out any engine write

`include "pdl_config.svh"

module pdl_spy_port
(
   input  logic                   clk_a,
   input  logic                   reset,
   input  pdl_pkg::spy_req_t      spy_req,
   input  logic                   spy_req_valid,
   output logic                   spy_req_ready,
   output logic [`PDL_DATA_W-1:0] spy_rdata,
   output logic                   spy_rdata_valid,
   input  logic                   spy_rdata_ready,
   input  logic                   a_write,
   output pdl_pkg::ram_port_t     port_b,
   input  logic [`PDL_DATA_W-1:0] q_b
);

   logic accept;
   logic write_blocked;
   logic rdata_held;

   assign write_blocked = a_write && spy_req_valid && spy_req.write;
   assign rdata_held    = spy_rdata_valid && !spy_rdata_ready;
   assign spy_req_ready = !write_blocked && !rdata_held;
   assign accept        = spy_req_valid && spy_req_ready;

   always_comb
   begin
      port_b.addr  = spy_req.addr;
      port_b.wdata = spy_req.data;
      port_b.wren  = accept && spy_req.write;
      port_b.rden  = accept && !spy_req.write;
   end

   // Read data straight from the RAM register, stable until the next rden
   assign spy_rdata = q_b;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         spy_rdata_valid <= 1'b0;
      end
      else if (port_b.rden)
      begin
         spy_rdata_valid <= 1'b1;
      end
      else if (spy_rdata_ready)
      begin
         spy_rdata_valid <= 1'b0;
      end
   end

endmodule

// File: source/pdl_top.sv
// PDL memory subsystem, engine and host spy port around one dual-port RAM
// All four external streams use valid/ready handshakes on clk_a

`include "pdl_config.svh"

module pdl_top
(
   input  logic                   clk_a,
   input  logic                   reset,
   input  pdl_pkg::pdl_cmd_t      cmd,
   input  logic                   cmd_valid,
   output logic                   cmd_ready,
   output pdl_pkg::pdl_resp_t     resp,
   output logic                   resp_valid,
   input  logic                   resp_ready,
   input  pdl_pkg::spy_req_t      spy_req,
   input  logic                   spy_req_valid,
   output logic                   spy_req_ready,
   output logic [`PDL_DATA_W-1:0] spy_rdata,
   output logic                   spy_rdata_valid,
   input  logic                   spy_rdata_ready
);

   import pdl_pkg::*;

   ram_port_t              port_a;
   ram_port_t              port_b;
   logic [`PDL_DATA_W-1:0] q_a;
   logic [`PDL_DATA_W-1:0] q_b;
   logic                   a_write;

   pdl_engine u_pdl_engine
   (
      .clk_a      (clk_a),
      .reset      (reset),
      .cmd        (cmd),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .resp       (resp),
      .resp_valid (resp_valid),
      .resp_ready (resp_ready),
      .port_a     (port_a),
      .q_a        (q_a),
      .a_write    (a_write)
   );

   pdl_spy_port u_pdl_spy_port
   (
      .clk_a           (clk_a),
      .reset           (reset),
      .spy_req         (spy_req),
      .spy_req_valid   (spy_req_valid),
      .spy_req_ready   (spy_req_ready),
      .spy_rdata       (spy_rdata),
      .spy_rdata_valid (spy_rdata_valid),
      .spy_rdata_ready (spy_rdata_ready),
      .a_write         (a_write),
      .port_b          (port_b),
      .q_b             (q_b)
   );

   pdl_dpram u_pdl_dpram
   (
      .clk_a  (clk_a),
      .reset  (reset),
      .port_a (port_a),
      .port_b (port_b),
      .q_a    (q_a),
      .q_b    (q_b)
   );

endmodule

// File: verification/pdl_tb_model.svh
// Reference model of the PDL memory, included inside the testbench module
// Tracks words, stack pointer and index in the order transfers are issued

`ifndef PDL_TB_MODEL_SVH
`define PDL_TB_MODEL_SVH

logic [`PDL_DATA_W-1:0] model_mem [0:`PDL_DEPTH-1];
logic [`PDL_ADDR_W-1:0] model_ptr;   // Last word pushed
logic [`PDL_ADDR_W-1:0] model_idx;

function automatic void reset_model();
   model_ptr = '0;
   model_idx = '0;
endfunction

// Expected read word of one engine command and zero for commands with no response
function automatic logic [`PDL_DATA_W-1:0] expect_cmd(input pdl_cmd_t c);
   logic [`PDL_DATA_W-1:0] word;
   word = '0;
   case (c.op)
      op_push:
      begin
         model_ptr = model_ptr + 1'b1;   // Pre-increment that wraps at 1024
         model_mem[model_ptr] = c.data;
      end
      op_pop:
      begin
         word = model_mem[model_ptr];
         model_ptr = model_ptr - 1'b1;
      end
      op_read_idx:  word = model_mem[model_idx];
      op_write_idx: model_mem[model_idx] = c.data;
      op_set_ptr:   model_ptr = c.addr;
      op_set_idx:   model_idx = c.addr;
      default:      word = '0;
   endcase
   return word;
endfunction

// Expected read word of one host access
function automatic logic [`PDL_DATA_W-1:0] expect_spy(input spy_req_t r);
   logic [`PDL_DATA_W-1:0] word;
   word = '0;
   if (r.write)
      model_mem[r.addr] = r.data;
   else
      word = model_mem[r.addr];
   return word;
endfunction

`endif

// File: verification/pdl_tb.sv
// Testbench for the PDL memory subsystem with stack, indexed, wrap, stall and host port tests
// Expected words come from the model in pdl_tb_model.svh

`include "pdl_config.svh"

module pdl_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import pdl_pkg::*;

   localparam int lifo_n = 64;
   localparam int idx_n  = 32;
   localparam int bp_n   = 32;
   localparam int host_n = 16;
   // Transfers on all four streams summed over the tests
   localparam int total_xfers    = 3*lifo_n + 7*idx_n + 13 + 5*bp_n + 7*host_n;
   localparam int timeout_cycles = 4*total_xfers + 200;

   logic                   clk_a = 1'b0;
   logic                   reset;
   pdl_cmd_t               cmd;
   logic                   cmd_valid;
   logic                   cmd_ready;
   pdl_resp_t              resp;
   logic                   resp_valid;
   logic                   resp_ready;
   spy_req_t               spy_req;
   logic                   spy_req_valid;
   logic                   spy_req_ready;
   logic [`PDL_DATA_W-1:0] spy_rdata;
   logic                   spy_rdata_valid;
   logic                   spy_rdata_ready;

   logic [`PDL_DATA_W-1:0] exp_resp [$];
   logic [`PDL_DATA_W-1:0] exp_spy [$];
   string                  test_name = "reset";
   int                     test_checks = 0;
   int                     test_errors = 0;
   int                     pass_count = 0;
   int                     fail_count = 0;
   int                     cycle_count;
   int                     seed = 23;
   int                     stall_seed = 23;   // Own sequence for the ready stalls
   logic                   stall_en = 1'b0;

   always #4 clk_a = ~clk_a;

   pdl_top u_pdl_top
   (
      .clk_a           (clk_a),
      .reset           (reset),
      .cmd             (cmd),
      .cmd_valid       (cmd_valid),
      .cmd_ready       (cmd_ready),
      .resp            (resp),
      .resp_valid      (resp_valid),
      .resp_ready      (resp_ready),
      .spy_req         (spy_req),
      .spy_req_valid   (spy_req_valid),
      .spy_req_ready   (spy_req_ready),
      .spy_rdata       (spy_rdata),
      .spy_rdata_valid (spy_rdata_valid),
      .spy_rdata_ready (spy_rdata_ready)
   );

   `include "pdl_tb_model.svh"

   task automatic check_word(input string name, input logic [`PDL_DATA_W-1:0] expected,
                             input logic [`PDL_DATA_W-1:0] actual);
      test_checks++;
      if (actual !== expected)
      begin
         $display("** Error %s: expected %h, actual %h", name, expected, actual);
         fail_count++;
         test_errors++;
      end
      else
         pass_count++;
   endtask

   // Called 1 ns after a rising edge and returns 1 ns after the accepting edge
   task automatic issue_cmd(input pdl_op_e op, input logic [`PDL_ADDR_W-1:0] addr,
                            input logic [`PDL_DATA_W-1:0] data);
      pdl_cmd_t c;
      logic [`PDL_DATA_W-1:0] word;
      c.op   = op;
      c.addr = addr;
      c.data = data;
      word = expect_cmd(c);
      if (op == op_pop || op == op_read_idx)
         exp_resp.push_back(word);
      cmd       = c;
      cmd_valid = 1'b1;
      @(negedge clk_a);
      while (!cmd_ready)
         @(negedge clk_a);
      @(posedge clk_a);
      #1;
      cmd_valid = 1'b0;
   endtask

   task automatic host_access(input logic write, input logic [`PDL_ADDR_W-1:0] addr,
                              input logic [`PDL_DATA_W-1:0] data);
      spy_req_t r;
      logic [`PDL_DATA_W-1:0] word;
      r.write = write;
      r.addr  = addr;
      r.data  = data;
      word = expect_spy(r);
      if (!write)
         exp_spy.push_back(word);
      spy_req       = r;
      spy_req_valid = 1'b1;
      @(negedge clk_a);
      while (!spy_req_ready)
         @(negedge clk_a);
      @(posedge clk_a);
      #1;
      spy_req_valid = 1'b0;
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_checks = 0;
      test_errors = 0;
   endtask

   // Waits until every expected word has been taken
   task automatic finish_test();
      while (exp_resp.size() != 0 || exp_spy.size() != 0)
      begin
         @(posedge clk_a);
         #1;
      end
      $display("%-6s %0d checks, %0d errors", test_name, test_checks, test_errors);
   endtask

   //----------------------------------------------------------------------
   // Ready stalls and response compare
   //----------------------------------------------------------------------

   always @(posedge clk_a)
   begin
      #1;
      resp_ready      = !stall_en || ($random(stall_seed) & 3) != 0;
      spy_rdata_ready = !stall_en || ($random(stall_seed) & 3) != 0;
   end

   // Sampled at the falling edge where valid, ready and data have settled
   always @(negedge clk_a)
   begin
      if (!reset && resp_valid && resp_ready)
      begin
         if (exp_resp.size() == 0)
         begin
            $display("%s: engine returned %h with no read outstanding", test_name, resp.data);
            fail_count++;
            test_errors++;
         end
         else
            check_word(test_name, exp_resp.pop_front(), resp.data);
      end
      if (!reset && spy_rdata_valid && spy_rdata_ready)
      begin
         if (exp_spy.size() == 0)
         begin
            $display("%s: spy port returned %h with no read outstanding", test_name, spy_rdata);
            fail_count++;
            test_errors++;
         end
         else
            check_word(test_name, exp_spy.pop_front(), spy_rdata);
      end
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < timeout_cycles)
      begin
         @(posedge clk_a);
         cycle_count++;
      end
      $display("Timeout: run still busy after %0d cycles in test %s", cycle_count, test_name);
      $display("test failed");
      $finish;
   end

   //----------------------------------------------------------------------
   // Tests
   //----------------------------------------------------------------------

   initial
   begin
      logic [`PDL_ADDR_W-1:0] addrs [0:idx_n-1];
      logic [`PDL_ADDR_W-1:0] base;
      cmd             = '0;
      cmd_valid       = 1'b0;
      resp_ready      = 1'b1;
      spy_req         = '0;
      spy_req_valid   = 1'b0;
      spy_rdata_ready = 1'b1;
      reset           = 1'b1;
      reset_model();
      repeat (5) @(posedge clk_a);
      #1;
      reset = 1'b0;

      start_test("reset");
      repeat (8)
      begin
         @(negedge clk_a);
         check_word(test_name, 0, resp_valid);
         check_word(test_name, 0, spy_rdata_valid);
         check_word(test_name, 1, cmd_ready);
         check_word(test_name, 1, spy_req_ready);
         check_word(test_name, 0, resp.data);
         check_word(test_name, 0, spy_rdata);
      end
      @(posedge clk_a);
      #1;
      finish_test();

      start_test("lifo");
      for (int i = 0; i < lifo_n; i++)
         issue_cmd(op_push, '0, $random(seed));
      for (int i = 0; i < lifo_n; i++)
         issue_cmd(op_pop, '0, '0);
      finish_test();

      start_test("index");
      for (int i = 0; i < idx_n; i++)
      begin
         addrs[i] = $random(seed);
         issue_cmd(op_set_idx, addrs[i], '0);
         issue_cmd(op_write_idx, '0, $random(seed));
         issue_cmd(op_read_idx, '0, '0);
      end
      for (int i = 0; i < idx_n; i++)
      begin
         issue_cmd(op_set_idx, addrs[i], '0);
         issue_cmd(op_read_idx, '0, '0);   // Last word written there
      end
      finish_test();

      start_test("wrap");
      issue_cmd(op_set_ptr, `PDL_DEPTH - 1, '0);
      issue_cmd(op_push, '0, $random(seed));   // Lands at address 0
      issue_cmd(op_push, '0, $random(seed));
      issue_cmd(op_set_idx, '0, '0);
      issue_cmd(op_read_idx, '0, '0);
      issue_cmd(op_pop, '0, '0);
      issue_cmd(op_pop, '0, '0);
      issue_cmd(op_push, '0, $random(seed));   // Address 0 again once back at 1023
      issue_cmd(op_read_idx, '0, '0);
      finish_test();

      start_test("stall");
      stall_en = 1'b1;
      base = model_ptr + 1'b1;
      for (int i = 0; i < bp_n; i++)
         issue_cmd(op_push, '0, $random(seed));
      for (int i = 0; i < bp_n; i++)
         host_access(1'b0, base + i, '0);
      for (int i = 0; i < bp_n; i++)
         issue_cmd(op_pop, '0, '0);
      finish_test();
      stall_en = 1'b0;

      start_test("host");
      base = model_ptr + 1'b1;
      for (int i = 0; i < host_n; i++)
         issue_cmd(op_push, '0, $random(seed));
      for (int i = 0; i < host_n; i++)
         host_access(1'b0, base + i, '0);
      for (int i = 0; i < host_n; i++)
      begin
         addrs[i] = $random(seed);
         host_access(1'b1, addrs[i], $random(seed));
      end
      for (int i = 0; i < host_n; i++)
      begin
         issue_cmd(op_set_idx, addrs[i], '0);
         issue_cmd(op_read_idx, '0, '0);
      end
      finish_test();

      $display("%0d checks passed, %0d checks failed", pass_count, fail_count);
      if (fail_count == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

// File: flist.f
+incdir+source
+incdir+verification
source/pdl_pkg.sv
source/pdl_dpram.sv
source/pdl_pointer.sv
source/pdl_engine.sv
source/pdl_spy_port.sv
source/pdl_top.sv
verification/pdl_tb.sv

// File: Bender.yml
package:
  name: pdl_memory

sources:
  - include_dirs:
      - source
    files:
      - source/pdl_pkg.sv
      - source/pdl_dpram.sv
      - source/pdl_pointer.sv
      - source/pdl_engine.sv
      - source/pdl_spy_port.sv
      - source/pdl_top.sv

  - target: test
    include_dirs:
      - source
      - verification
    files:
      - verification/pdl_tb.sv
